// ==== common/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

	//////////////////////////////////////////////////////////////////////////
	// Frame geometry
	//////////////////////////////////////////////////////////////////////////

	localparam int ADC_PACKET_WORDS = 256; // Samples per ADC frame
	localparam int ADC_FIFO_AW      = 9;   // 512 sample slots
	localparam int TX_FIFO_AW       = 4;   // 16 stream words
	localparam int STATUS_DIV       = 31249; // Terminal count of the status divider
	localparam int HDR_WORDS        = 6;
	localparam int STATUS_WORDS     = 2;

	// Packet kind codes in the upper half of the type word
	localparam logic [15:0] KIND_ADC    = 16'h0ADC;
	localparam logic [15:0] KIND_STATUS = 16'h05A7;

	typedef logic [31:0] adc_word_t;
	typedef logic [9:0]  fill_t; // Wide enough for a full 512-entry FIFO

	// f36 flag nibble with zero occupancy for a full word
	typedef struct packed {
		logic [1:0] occ;
		logic       eof;
		logic       sof;
	} f36_flags_t;

	typedef struct packed {
		f36_flags_t  flags;
		logic [31:0] data;
	} f36_word_t;

	// Station addresses as seen by the framer
	typedef struct packed {
		logic [47:0] my_mac;
		logic [31:0] my_ip;
		logic [47:0] dst_mac;
		logic [31:0] dst_ip;
	} net_cfg_t;

endpackage

`default_nettype wire

// ==== common/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

	localparam int WB_AW = 8;
	localparam int WB_DW = 32;

	// Register index from byte address bits 4:2
	localparam logic [2:0] REG_MY_IP      = 3'd0;
	localparam logic [2:0] REG_MY_MAC_HI  = 3'd1;
	localparam logic [2:0] REG_MY_MAC_LO  = 3'd2;
	localparam logic [2:0] REG_DST_IP     = 3'd3;
	localparam logic [2:0] REG_DST_MAC_HI = 3'd4;
	localparam logic [2:0] REG_DST_MAC_LO = 3'd5;
	localparam logic [2:0] REG_CONTROL    = 3'd6;
	localparam logic [2:0] REG_STATUS     = 3'd7;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_m2s_t;

	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat;
	} wb_s2m_t;

	typedef struct packed {
		logic status_enable; // Bit 1
		logic adc_enable;    // Bit 0
	} ctrl_t;

	typedef struct packed {
		logic [5:0]  rsvd_hi;
		logic [9:0]  adc_fill;
		logic [14:0] rsvd_lo;
		logic        overflow; // Sticky until the ADC is disabled
	} status_t;

endpackage

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_fifo
	import eth_pkg::*;
#(
	parameter type payload_t = logic [31:0],
	parameter int  AW        = 4
) (
	input  wire      clk_i,
	input  wire      rst_i,
	input  wire      flush_i,
	input  wire      push_i,
	input  payload_t din_i,
	input  wire      pop_i,
	output payload_t dout_o,
	output logic     empty_o,
	output logic     full_o,
	output fill_t    fill_o
);

	payload_t mem [2**AW];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign empty_o = (count == '0);
	assign full_o  = count[AW];   // Exactly 2^AW entries
	assign fill_o  = fill_t'(count);
	assign dout_o  = mem[rd_ptr]; // Show-ahead head

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_config_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_config_regs
	import eth_pkg::*;
	import wb_pkg::*;
(
	input  wire     clk_i,
	input  wire     rst_i,
	input  wb_m2s_t wb_i,
	output wb_s2m_t wb_o,
	input  status_t status_i,
	output net_cfg_t cfg_o,
	output ctrl_t   ctrl_o
);

	logic [31:0] my_ip_q;
	logic [15:0] my_mac_hi_q;
	logic [31:0] my_mac_lo_q;
	logic [31:0] dst_ip_q;
	logic [15:0] dst_mac_hi_q;
	logic [31:0] dst_mac_lo_q;
	logic [31:0] ctrl_q;
	logic [31:0] rd_data;
	logic [31:0] dat_q;
	logic        ack_q;
	logic        req;
	logic [2:0]  reg_idx;

	// New access rather than the one being acked
	assign req     = wb_i.cyc && wb_i.stb && !ack_q;
	assign reg_idx = wb_i.adr[4:2];

	always_comb begin
		case (reg_idx)
			REG_MY_IP:      rd_data = my_ip_q;
			REG_MY_MAC_HI:  rd_data = {16'h0000, my_mac_hi_q};
			REG_MY_MAC_LO:  rd_data = my_mac_lo_q;
			REG_DST_IP:     rd_data = dst_ip_q;
			REG_DST_MAC_HI: rd_data = {16'h0000, dst_mac_hi_q};
			REG_DST_MAC_LO: rd_data = dst_mac_lo_q;
			REG_CONTROL:    rd_data = ctrl_q;
			default:        rd_data = status_i;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			ack_q        <= 1'b0;
			my_ip_q      <= '0;
			my_mac_hi_q  <= '0;
			my_mac_lo_q  <= '0;
			dst_ip_q     <= '0;
			dst_mac_hi_q <= '0;
			dst_mac_lo_q <= '0;
			ctrl_q       <= '0;
		end else begin
			ack_q <= req;
			if (req && wb_i.we) begin
				case (reg_idx)
					REG_MY_IP:      my_ip_q      <= wb_i.dat;
					REG_MY_MAC_HI:  my_mac_hi_q  <= wb_i.dat[15:0];
					REG_MY_MAC_LO:  my_mac_lo_q  <= wb_i.dat;
					REG_DST_IP:     dst_ip_q     <= wb_i.dat;
					REG_DST_MAC_HI: dst_mac_hi_q <= wb_i.dat[15:0];
					REG_DST_MAC_LO: dst_mac_lo_q <= wb_i.dat;
					REG_CONTROL:    ctrl_q       <= wb_i.dat;
					default: ; // Status is read only
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req)
			dat_q <= rd_data;
	end

	assign wb_o.ack = ack_q;
	assign wb_o.dat = dat_q;

	assign cfg_o.my_mac  = {my_mac_hi_q, my_mac_lo_q};
	assign cfg_o.my_ip   = my_ip_q;
	assign cfg_o.dst_mac = {dst_mac_hi_q, dst_mac_lo_q};
	assign cfg_o.dst_ip  = dst_ip_q;
	assign ctrl_o        = ctrl_t'(ctrl_q[1:0]);

endmodule

`default_nettype wire

// ==== src/status_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module status_timer
	import eth_pkg::*;
(
	input  wire         clk_i,
	input  wire         rst_i,
	input  wire         enable_i,
	output logic        req_o,
	output logic [15:0] seq_o
);

	logic [15:0] div_q;
	logic        div_end;

	assign div_end = (div_q == 16'(STATUS_DIV));

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			div_q <= '0;
			req_o <= 1'b0;
			seq_o <= '0;
		end else if (!enable_i) begin
			div_q <= '0; // Restart numbering on next enable
			req_o <= 1'b0;
			seq_o <= '0;
		end else begin
			req_o <= div_end;
			if (div_end)
				div_q <= '0;
			else
				div_q <= div_q + 1'b1;
			if (req_o)
				seq_o <= seq_o + 1'b1; // Number of the next request
		end
	end

endmodule

`default_nettype wire

// ==== adc_path/adc_packetizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_packetizer
	import eth_pkg::*;
(
	input  wire       clk_i,
	input  wire       rst_i,
	input  wire       enable_i,
	input  adc_word_t sample_i,
	input  wire       valid_i,
	input  wire       pop_i,
	output adc_word_t data_o,
	output logic      pkt_ready_o,
	output fill_t     fill_o,
	output logic      overflow_o
);

	logic full;
	logic empty;
	logic push;

	// No back-pressure towards the ADC so a sample meeting a full FIFO is lost
	assign push = enable_i && valid_i && !full;

	stream_fifo #(
		.payload_t (adc_word_t),
		.AW        (ADC_FIFO_AW)
	) u_sample_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.flush_i (!enable_i),
		.push_i  (push),
		.din_i   (sample_i),
		.pop_i   (pop_i && !empty),
		.dout_o  (data_o),
		.empty_o (empty),
		.full_o  (full),
		.fill_o  (fill_o)
	);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			overflow_o <= 1'b0;
		else if (!enable_i)
			overflow_o <= 1'b0;
		else if (valid_i && full)
			overflow_o <= 1'b1;
	end

	assign pkt_ready_o = (fill_o >= fill_t'(ADC_PACKET_WORDS)); // A whole frame waits

endmodule

`default_nettype wire

// ==== tx_framer/packet_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_builder
	import eth_pkg::*;
(
	input  wire         clk_i,
	input  wire         rst_i,
	input  net_cfg_t    cfg_i,
	input  wire         adc_ready_i,
	input  adc_word_t   adc_data_i,
	output logic        adc_pop_o,
	input  fill_t       adc_fill_i,
	input  wire         status_req_i,
	input  wire  [15:0] status_seq_i,
	output f36_word_t   tx_o,
	output logic        tx_src_rdy_o,
	input  wire         tx_dst_rdy_i
);

	typedef enum logic [1:0] {S_IDLE, S_HDR, S_PAY} state_t;

	state_t      state;
	logic        is_adc;     // Kind of the frame in progress
	logic [8:0]  idx;        // Word index within header or payload
	logic        pend_q;     // One status request waiting
	logic [15:0] pend_seq_q;
	logic [15:0] frame_seq_q;
	logic        tx_full;
	logic        tx_empty;
	logic        push;
	logic        pay_last;
	f36_word_t   word;

	assign push     = (state != S_IDLE) && !tx_full;
	assign pay_last = is_adc ? (idx == 9'(ADC_PACKET_WORDS - 1)) : (idx == 9'(STATUS_WORDS - 1));
	assign adc_pop_o = push && (state == S_PAY) && is_adc;

	//////////////////////////////////////////////////////////////////////////
	// Word generation
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		word = '0;
		if (state == S_HDR) begin
			case (idx[2:0])
				3'd0: word.data = cfg_i.dst_mac[47:16];
				3'd1: word.data = {cfg_i.dst_mac[15:0], cfg_i.my_mac[47:32]};
				3'd2: word.data = cfg_i.my_mac[31:0];
				3'd3: word.data = cfg_i.dst_ip;
				3'd4: word.data = cfg_i.my_ip;
				default: word.data = is_adc ? {KIND_ADC, 16'(ADC_PACKET_WORDS)}
				                            : {KIND_STATUS, 16'(STATUS_WORDS)};
			endcase
			word.flags.sof = (idx == '0);
		end else begin
			if (is_adc)
				word.data = adc_data_i; // Show-ahead head of the sample FIFO
			else if (idx == '0)
				word.data = 32'(frame_seq_q);
			else
				word.data = 32'(adc_fill_i);
			word.flags.eof = pay_last;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Framing FSM
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state       <= S_IDLE;
			is_adc      <= 1'b0;
			idx         <= '0;
			pend_q      <= 1'b0;
			pend_seq_q  <= '0;
			frame_seq_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					idx <= '0;
					if (adc_ready_i) begin // ADC wins a tie
						is_adc <= 1'b1;
						state  <= S_HDR;
					end else if (pend_q) begin
						is_adc      <= 1'b0;
						frame_seq_q <= pend_seq_q;
						pend_q      <= 1'b0;
						state       <= S_HDR;
					end
				end
				S_HDR: if (push) begin
					if (idx == 9'(HDR_WORDS - 1)) begin
						idx   <= '0;
						state <= S_PAY;
					end else
						idx <= idx + 1'b1;
				end
				default: if (push) begin
					if (pay_last)
						state <= S_IDLE;
					else
						idx <= idx + 1'b1;
				end
			endcase
			if (status_req_i) begin // Later requests merge into the pending one
				pend_q     <= 1'b1;
				pend_seq_q <= status_seq_i;
			end
		end
	end

	stream_fifo #(
		.payload_t (f36_word_t),
		.AW        (TX_FIFO_AW)
	) u_tx_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.flush_i (1'b0),
		.push_i  (push),
		.din_i   (word),
		.pop_i   (tx_dst_rdy_i),
		.dout_o  (tx_o),
		.empty_o (tx_empty),
		.full_o  (tx_full),
		.fill_o  ()
	);

	assign tx_src_rdy_o = !tx_empty;

endmodule

`default_nettype wire

// ==== src/eth_stream_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_stream_top
	import eth_pkg::*;
	import wb_pkg::*;
(
	input  wire       GMII_GTX_CLK_int,
	input  wire       wb_rst,
	input  wb_m2s_t   wb_i,
	output wb_s2m_t   wb_o,
	input  adc_word_t adc_sample_i,
	input  wire       adc_valid_i,
	output f36_word_t tx_o,
	output logic      tx_src_rdy_o,
	input  wire       tx_dst_rdy_i
);

	net_cfg_t    cfg;
	ctrl_t       ctrl;
	status_t     status;
	logic        status_req;
	logic [15:0] status_seq;
	adc_word_t   adc_data;
	logic        adc_pop;
	logic        adc_ready;
	fill_t       adc_fill;
	logic        adc_overflow;

	// Status word seen by software
	always_comb begin
		status          = '0;
		status.overflow = adc_overflow;
		status.adc_fill = adc_fill;
	end

	wb_config_regs u_regs (
		.clk_i    (GMII_GTX_CLK_int),
		.rst_i    (wb_rst),
		.wb_i     (wb_i),
		.wb_o     (wb_o),
		.status_i (status),
		.cfg_o    (cfg),
		.ctrl_o   (ctrl)
	);

	status_timer u_timer (
		.clk_i    (GMII_GTX_CLK_int),
		.rst_i    (wb_rst),
		.enable_i (ctrl.status_enable),
		.req_o    (status_req),
		.seq_o    (status_seq)
	);

	adc_packetizer u_adc (
		.clk_i       (GMII_GTX_CLK_int),
		.rst_i       (wb_rst),
		.enable_i    (ctrl.adc_enable),
		.sample_i    (adc_sample_i),
		.valid_i     (adc_valid_i),
		.pop_i       (adc_pop),
		.data_o      (adc_data),
		.pkt_ready_o (adc_ready),
		.fill_o      (adc_fill),
		.overflow_o  (adc_overflow)
	);

	packet_builder u_builder (
		.clk_i        (GMII_GTX_CLK_int),
		.rst_i        (wb_rst),
		.cfg_i        (cfg),
		.adc_ready_i  (adc_ready),
		.adc_data_i   (adc_data),
		.adc_pop_o    (adc_pop),
		.adc_fill_i   (adc_fill),
		.status_req_i (status_req),
		.status_seq_i (status_seq),
		.tx_o         (tx_o),
		.tx_src_rdy_o (tx_src_rdy_o),
		.tx_dst_rdy_i (tx_dst_rdy_i)
	);

endmodule

`default_nettype wire

// ==== verification/eth_stream_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_stream_sva
	import eth_pkg::*;
	import wb_pkg::*;
(
	input  wire       clk_i,
	input  wire       rst_i,
	input  wb_m2s_t   wb_req_i,
	input  wb_s2m_t   wb_rsp_i,
	input  f36_word_t tx_i,
	input  wire       src_rdy_i,
	input  wire       dst_rdy_i
);

	int   stable_fails = 0;
	int   ack_fails    = 0;
	int   sof_fails    = 0;
	int   fail_count;
	logic in_frame; // Between an accepted SOF and its EOF
	logic xfer;

	assign xfer       = src_rdy_i && dst_rdy_i;
	assign fail_count = stable_fails + ack_fails + sof_fails;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			in_frame <= 1'b0;
		else if (xfer && tx_i.flags.eof)
			in_frame <= 1'b0;
		else if (xfer && tx_i.flags.sof)
			in_frame <= 1'b1;
	end

	held_word_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		src_rdy_i && !dst_rdy_i |=> src_rdy_i && $stable(tx_i))
	else begin
		stable_fails++;
		$error("Stream word changed while held by the sink");
	end

	ack_after_request: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
	else begin
		ack_fails++;
		$error("Wishbone ack without a preceding cyc and stb");
	end

	sof_needs_eof: assert property (@(posedge clk_i) disable iff (rst_i)
		xfer && tx_i.flags.sof |-> !in_frame)
	else begin
		sof_fails++;
		$error("Second SOF before the EOF of the previous frame");
	end

endmodule

bind eth_stream_top eth_stream_sva u_sva (
	.clk_i     (GMII_GTX_CLK_int),
	.rst_i     (wb_rst),
	.wb_req_i  (wb_i),
	.wb_rsp_i  (wb_o),
	.tx_i      (tx_o),
	.src_rdy_i (tx_src_rdy_o),
	.dst_rdy_i (tx_dst_rdy_i)
);

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o; // 100 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/eth_stream_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_stream_tb
	import eth_pkg::*;
	import wb_pkg::*;
();

	localparam int WAIT_LIMIT = 40000;

	logic      clk;
	logic      rst;
	wb_m2s_t   wb_m;
	wb_s2m_t   wb_s;
	adc_word_t adc_sample;
	logic      adc_valid;
	f36_word_t tx;
	logic      tx_src_rdy;
	logic      tx_dst_rdy;

	f36_word_t rx_q[$];  // Words taken from the stream
	f36_word_t exp_q[$];
	int        frames_seen  = 0;
	int        check_errors = 0;
	int        other_errors = 0;
	bit        aborted      = 1'b0;
	bit        bp_mode      = 1'b0; // Random sink ready
	logic      dst_rdy_level;
	net_cfg_t  cfg;

	tb_clkgen u_clkgen (
		.clk_o (clk),
		.rst_o (rst)
	);

	eth_stream_top u_dut (
		.GMII_GTX_CLK_int (clk),
		.wb_rst           (rst),
		.wb_i             (wb_m),
		.wb_o             (wb_s),
		.adc_sample_i     (adc_sample),
		.adc_valid_i      (adc_valid),
		.tx_o             (tx),
		.tx_src_rdy_o     (tx_src_rdy),
		.tx_dst_rdy_i     (tx_dst_rdy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stream sink and monitor
	////////////////////////////////////////////////////////////////////////////

	initial begin
		tx_dst_rdy = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (bp_mode)
				tx_dst_rdy = ($urandom() & 32'h1) != 0;
			else
				tx_dst_rdy = dst_rdy_level;
		end
	end

	// Sampled midway between edges where all is stable
	always @(negedge clk) begin
		if (!rst && tx_src_rdy && tx_dst_rdy) begin
			rx_q.push_back(tx);
			if (tx.flags.eof)
				frames_seen++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(string what, f36_word_t got, f36_word_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s got %b/%h, expected %b/%h", $time, what,
				got.flags, got.data, exp.flags, exp.data);
		end
	endtask

	task automatic check_reg(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// With fill_floor set the fill level is a lower bound
	task automatic check_status(string what, status_t got, status_t exp, bit fill_floor);
		bit fill_ok;
		if (fill_floor)
			fill_ok = got.adc_fill >= exp.adc_fill;
		else
			fill_ok = got.adc_fill === exp.adc_fill;
		if (got.overflow !== exp.overflow || !fill_ok || got.rsvd_hi !== '0
				|| got.rsvd_lo !== '0) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s got ovf %b fill %0d, expected ovf %b fill %0d",
				$time, what, got.overflow, got.adc_fill, exp.overflow, exp.adc_fill);
		end
	endtask

	task automatic report_abort(string why);
		other_errors++;
		aborted = 1'b1;
		$display("Timeout after %0d cycles: %s", WAIT_LIMIT, why);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus and sample drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_access(bit we, logic [2:0] idx, logic [31:0] wdata,
			output logic [31:0] rdata);
		int waited;
		rdata = '0;
		if (aborted)
			return;
		@(posedge clk);
		#1;
		wb_m.cyc = 1'b1;
		wb_m.stb = 1'b1;
		wb_m.we  = we;
		wb_m.adr = {3'b000, idx, 2'b00};
		wb_m.dat = wdata;
		waited = 0;
		@(negedge clk);
		while (!wb_s.ack && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (wb_s.ack)
			rdata = wb_s.dat;
		else
			report_abort("no Wishbone ack");
		@(posedge clk);
		#1;
		wb_m.cyc = 1'b0;
		wb_m.stb = 1'b0;
		wb_m.we  = 1'b0;
	endtask

	task automatic wb_write(logic [2:0] idx, logic [31:0] data);
		logic [31:0] ignored;
		bus_access(1'b1, idx, data, ignored);
	endtask

	task automatic wb_read(logic [2:0] idx, output logic [31:0] data);
		bus_access(1'b0, idx, 32'h0, data);
	endtask

	task automatic feed_samples(adc_word_t base, int count);
		if (aborted)
			return;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			adc_valid  = 1'b1;
			adc_sample = base + adc_word_t'(i);
		end
		@(posedge clk);
		#1;
		adc_valid = 1'b0;
	endtask

	task automatic wait_frames(int target, string what);
		int waited;
		waited = 0;
		while (!aborted && frames_seen < target) begin
			@(posedge clk);
			waited++;
			if (waited >= WAIT_LIMIT)
				report_abort(what);
		end
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (!aborted && rst !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited >= WAIT_LIMIT)
				report_abort("reset never released");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected frames
	////////////////////////////////////////////////////////////////////////////

	function automatic f36_word_t make_word(logic [31:0] data, logic sof, logic eof);
		f36_word_t w;
		w.flags.occ = 2'b00; // Always a full word
		w.flags.eof = eof;
		w.flags.sof = sof;
		w.data      = data;
		return w;
	endfunction

	task automatic expect_header(logic [15:0] kind, logic [15:0] len);
		exp_q.push_back(make_word(cfg.dst_mac[47:16], 1'b1, 1'b0));
		exp_q.push_back(make_word({cfg.dst_mac[15:0], cfg.my_mac[47:32]}, 1'b0, 1'b0));
		exp_q.push_back(make_word(cfg.my_mac[31:0], 1'b0, 1'b0));
		exp_q.push_back(make_word(cfg.dst_ip, 1'b0, 1'b0));
		exp_q.push_back(make_word(cfg.my_ip, 1'b0, 1'b0));
		exp_q.push_back(make_word({kind, len}, 1'b0, 1'b0)); // Type word
	endtask

	task automatic compare_stream(string what);
		int n;
		n = 0;
		while (exp_q.size() > 0) begin
			if (rx_q.size() == 0) begin
				other_errors++;
				$display("%s: stream is %0d words short", what, exp_q.size());
				exp_q.delete();
			end else begin
				check_word($sformatf("%s word %0d", what, n), rx_q.pop_front(),
					exp_q.pop_front());
				n++;
			end
		end
		if (rx_q.size() != 0) begin
			other_errors++;
			$display("%s: %0d unexpected extra words on the stream", what, rx_q.size());
			rx_q.delete();
		end
	endtask

	task automatic configure_stations();
		cfg.my_mac  = {16'($urandom()), $urandom()};
		cfg.dst_mac = {16'($urandom()), $urandom()};
		cfg.my_ip   = $urandom();
		cfg.dst_ip  = $urandom();
		wb_write(REG_MY_IP, cfg.my_ip);
		wb_write(REG_MY_MAC_HI, {16'h0000, cfg.my_mac[47:32]});
		wb_write(REG_MY_MAC_LO, cfg.my_mac[31:0]);
		wb_write(REG_DST_IP, cfg.dst_ip);
		wb_write(REG_DST_MAC_HI, {16'h0000, cfg.dst_mac[47:32]});
		wb_write(REG_DST_MAC_LO, cfg.dst_mac[31:0]);
	endtask

	task automatic run_adc_frame(string what);
		adc_word_t base;
		int        target;
		base   = $urandom();
		target = frames_seen + 1;
		expect_header(KIND_ADC, 16'(ADC_PACKET_WORDS));
		for (int i = 0; i < ADC_PACKET_WORDS; i++)
			exp_q.push_back(make_word(base + adc_word_t'(i), 1'b0,
				i == ADC_PACKET_WORDS - 1));
		feed_samples(base, ADC_PACKET_WORDS);
		wait_frames(target, {what, " never completed"});
		compare_stream(what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic access_registers();
		logic [31:0] vals [7];
		logic [31:0] rdata;
		logic [31:0] expv;
		for (int i = 0; i < 7; i++) begin
			vals[i] = $urandom();
			wb_write(3'(i), vals[i]);
		end
		for (int i = 0; i < 7; i++) begin
			wb_read(3'(i), rdata);
			expv = vals[i];
			if (3'(i) == REG_MY_MAC_HI || 3'(i) == REG_DST_MAC_HI)
				expv = {16'h0000, vals[i][15:0]}; // Only MAC bits 47:32 exist
			check_reg($sformatf("register %0d", i), rdata, expv);
		end
		wb_write(REG_CONTROL, 32'h0);
		wb_write(REG_STATUS, $urandom()); // Dropped by the slave
		wb_read(REG_STATUS, rdata);
		check_status("status with ADC off", status_t'(rdata), '0, 1'b0);
	endtask

	task automatic send_adc_frame();
		configure_stations();
		wb_write(REG_CONTROL, 32'h1);
		run_adc_frame("ADC frame");
	endtask

	task automatic receive_status_frames();
		int target;
		wb_write(REG_CONTROL, 32'h2);
		for (int n = 0; n < 2; n++) begin
			target = frames_seen + 1;
			expect_header(KIND_STATUS, 16'(STATUS_WORDS));
			exp_q.push_back(make_word(32'(n), 1'b0, 1'b0));  // Sequence number
			exp_q.push_back(make_word(32'h0, 1'b0, 1'b1));   // Empty sample FIFO
			wait_frames(target, "status frame missing");
			compare_stream($sformatf("status frame %0d", n));
		end
		wb_write(REG_CONTROL, 32'h0);
	endtask

	task automatic apply_back_pressure();
		wb_write(REG_CONTROL, 32'h1);
		bp_mode = 1'b1;
		run_adc_frame("ADC frame under back-pressure");
		bp_mode = 1'b0;
	endtask

	task automatic force_overflow();
		logic [31:0] rdata;
		status_t     exp_st;
		dst_rdy_level = 1'b0; // Sink stalls for the whole test
		wb_write(REG_CONTROL, 32'h1);
		feed_samples($urandom(), 800);
		wb_read(REG_STATUS, rdata);
		exp_st          = '0;
		exp_st.overflow = 1'b1;
		exp_st.adc_fill = fill_t'(ADC_PACKET_WORDS);
		check_status("status after overflow", status_t'(rdata), exp_st, 1'b1);
		// Stalled frame waits at the head of the stream
		if (tx_src_rdy !== 1'b1) begin
			other_errors++;
			$display("Stream offers no word although a stalled frame is waiting");
		end
		check_word("stalled head word", tx, make_word(cfg.dst_mac[47:16], 1'b1, 1'b0));
		wb_write(REG_CONTROL, 32'h0);
		wb_read(REG_STATUS, rdata);
		check_status("status after ADC disable", status_t'(rdata), '0, 1'b0);
	endtask

	initial begin
		void'($urandom(32'h9ca9_b0ef));
		wb_m          = '0;
		adc_sample    = '0;
		adc_valid     = 1'b0;
		dst_rdy_level = 1'b1;
		wait_reset_release();
		access_registers();
		send_adc_frame();
		receive_status_frames();
		apply_back_pressure();
		force_overflow();
		repeat (4) @(posedge clk);
		$display("Errors: %0d failed checks, %0d other failures, %0d assertion failures",
			check_errors, other_errors, u_dut.u_sva.fail_count);
		if (check_errors == 0 && other_errors == 0 && u_dut.u_sva.fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/eth_pkg.sv
common/wb_pkg.sv
src/stream_fifo.sv
src/wb_config_regs.sv
src/status_timer.sv
adc_path/adc_packetizer.sv
tx_framer/packet_builder.sv
src/eth_stream_top.sv
verification/eth_stream_sva.sv
verification/tb_clkgen.sv
verification/eth_stream_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module eth_stream_tb -f vlog.f --Mdir obj_dir -o eth_stream_sim
	./obj_dir/eth_stream_sim +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
